// ==== rtl/pulse_daq_defines.svh ====
`ifndef PULSE_DAQ_DEFINES_SVH
`define PULSE_DAQ_DEFINES_SVH

// ====================
// widths
`define SAMPLE_W        14          // adc code width
`define STAMP_W         26          // timestamp width

// ====================
// window geometry
`define WIN_TAPS        21          // samples held per channel
`define PEAK_TAP        19          // candidate peak, neighbours 20 and 18
`define TAIL_TAP        1           // tail sample

// ====================
// sample levels
`define NEG_LIMIT       8192        // codes from here up are negative
`define FULL_SCALE      16384       // inversion base
`define CLIP_LIMIT      8000        // stored as zero at or above this
`define PEAK_THRESH_A   2760
`define PEAK_THRESH_B   230         // 12x scaled test folded into the threshold

`define TIME_WRAP       49999999    // last count before returning to 0

`endif

// ==== rtl/pulse_daq_pkg.sv ====
`include "pulse_daq_defines.svh"

package pulse_daq_pkg;

    // one adc code or inverted sample
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // free running event time
    typedef logic [`STAMP_W-1:0] stamp_t;

    // ====================
    // host readout word
    // channel a in the low half, channel b in the high half,
    // two zero bits above each sample
    typedef struct packed
    {
        logic [1:0]  pad_hi;        // bits 31:30
        sample_t     lane_b;        // bits 29:16
        logic [1:0]  pad_lo;        // bits 15:14
        sample_t     lane_a;        // bits 13:0
    } lane_pair_t;

endpackage

// ==== rtl/pulse_channel.sv ====
`include "pulse_daq_defines.svh"

module pulse_channel #(
    parameter int unsigned THRESHOLD = `PEAK_THRESH_A   // peak must exceed this
) (
    input  logic                   ADA_DCO,
    input  logic                   hps_fpga_reset_n,
    input  pulse_daq_pkg::sample_t raw,             // raw adc code
    output logic                   hit,             // one cycle per detection
    output pulse_daq_pkg::sample_t peak,            // held peak, zero when clipped
    output pulse_daq_pkg::sample_t tail             // held tail, zero when clipped
);

    import pulse_daq_pkg::*;

    // ====================
    // sample qualification

    logic    valid;                 // negative code, window advances
    sample_t inv;                   // inverted negative sample

    assign valid = (raw >= `NEG_LIMIT);
    // codes below NEG_LIMIT never reach the window, so no overflow here
    assign inv   = sample_t'(`FULL_SCALE - raw);

    // ====================
    // sample window
    // tap 0 is the newest, tap WIN_TAPS-1 the oldest

    sample_t win [`WIN_TAPS];

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            win <= '{default: '0};
        end
        else if (valid)                                 // positive codes freeze it
        begin
            for (int i = `WIN_TAPS - 1; i > 0; i--)
            begin
                win[i] <= win[i-1];
            end
            win[0] <= inv;
        end
    end

    // ====================
    // local maximum detector

    sample_t pre_peak;              // older neighbour
    sample_t cand;                  // candidate peak
    sample_t post_peak;             // newer neighbour
    sample_t tail_smp;
    logic    is_max;
    logic    clipped;

    assign pre_peak  = win[`PEAK_TAP + 1];
    assign cand      = win[`PEAK_TAP];
    assign post_peak = win[`PEAK_TAP - 1];
    assign tail_smp  = win[`TAIL_TAP];

    // evaluated on the window before the shift
    assign is_max  = valid
                   && (pre_peak <= cand)                // rising into the peak
                   && (cand >= post_peak)               // falling after it
                   && (cand > THRESHOLD);
    assign clipped = (cand >= `CLIP_LIMIT);             // saturated pulse

    // ====================
    // held result

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            hit  <= 1'b0;
            peak <= '0;
            tail <= '0;
        end
        else
        begin
            hit <= is_max;                              // pulses for clipped peaks too
            if (is_max)
            begin
                if (clipped)
                begin
                    peak <= '0;
                    tail <= '0;
                end
                else
                begin
                    peak <= cand;
                    tail <= tail_smp;
                end
            end
        end
    end

    // ====================
    // checks

    // a held peak always came through the clip filter
    peak_below_clip: assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        peak < `CLIP_LIMIT
    );

    // hit is a single pulse seen by the readout
    hit_single_cycle: assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        hit |=> !hit
    );

endmodule

// ==== rtl/event_readout.sv ====
`include "pulse_daq_defines.svh"

module event_readout (
    input  logic                       ADA_DCO,
    input  logic                       hps_fpga_reset_n,
    input  logic                       hit_b,       // channel b detection
    input  pulse_daq_pkg::sample_t     peak_a,
    input  pulse_daq_pkg::sample_t     tail_a,
    input  pulse_daq_pkg::sample_t     peak_b,
    input  pulse_daq_pkg::sample_t     tail_b,
    input  logic                       hps_read,    // async level from host
    output pulse_daq_pkg::lane_pair_t  peak_out,
    output pulse_daq_pkg::lane_pair_t  tail_out,
    output pulse_daq_pkg::stamp_t      time_out
);

    import pulse_daq_pkg::*;

    // ====================
    // timestamp

    stamp_t cnt;                    // free running, wraps at TIME_WRAP
    stamp_t held_stamp;             // time of last channel b hit

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            cnt <= '0;
        end
        else if (cnt == stamp_t'(`TIME_WRAP))
        begin
            cnt <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            held_stamp <= '0;
        else if (hit_b)
            held_stamp <= cnt;                          // latch on every b event
    end

    // ====================
    // host read strobe

    logic rd_s1;                    // first sync stage
    logic rd_s2;                    // second sync stage
    logic rd_s3;                    // previous rd_s2, for the edge
    logic rd_edge;

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            rd_s1 <= 1'b0;
            rd_s2 <= 1'b0;
            rd_s3 <= 1'b0;
        end
        else
        begin
            rd_s1 <= hps_read;
            rd_s2 <= rd_s1;
            rd_s3 <= rd_s2;
        end
    end

    assign rd_edge = rd_s2 && !rd_s3;                   // rising, after sync

    // ====================
    // snapshots

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            peak_out <= '0;
            tail_out <= '0;
            time_out <= '0;
        end
        else if (rd_edge)
        begin
            peak_out <= '{pad_hi: 2'b00, lane_b: peak_b, pad_lo: 2'b00, lane_a: peak_a};
            tail_out <= '{pad_hi: 2'b00, lane_b: tail_b, pad_lo: 2'b00, lane_a: tail_a};
            time_out <= held_stamp;
        end
    end

    // host sees steady words between reads
    snap_only_on_read: assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        !$stable({peak_out, tail_out, time_out}) |-> $past(rd_edge)
    );

endmodule

// ==== rtl/pulse_daq_top.sv ====
`include "pulse_daq_defines.svh"

module pulse_daq_top (
    input  logic                  ADA_DCO,
    input  logic                  hps_fpga_reset_n,
    input  logic [`SAMPLE_W-1:0]  ada_d,            // channel a raw codes
    input  logic [`SAMPLE_W-1:0]  adb_d,            // channel b raw codes
    input  logic                  hps_read,         // host read level
    output logic [31:0]           peak_out,         // b in 29:16, a in 13:0
    output logic [31:0]           tail_out,         // same packing as peak_out
    output logic [`STAMP_W-1:0]   time_out          // time of last b event
);

    import pulse_daq_pkg::*;

    // ====================
    // channel results

    sample_t peak_a;
    sample_t tail_a;
    sample_t peak_b;
    sample_t tail_b;
    logic    hit_b;                 // only b events are timestamped

    pulse_channel #(
        .THRESHOLD (`PEAK_THRESH_A)
    ) u_chan_a (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .raw              (ada_d),
        .hit              (),
        .peak             (peak_a),
        .tail             (tail_a)
    );

    // both channels share the a-side clock
    pulse_channel #(
        .THRESHOLD (`PEAK_THRESH_B)
    ) u_chan_b (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .raw              (adb_d),
        .hit              (hit_b),
        .peak             (peak_b),
        .tail             (tail_b)
    );

    // ====================
    // host side

    event_readout u_readout (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .hit_b            (hit_b),
        .peak_a           (peak_a),
        .tail_a           (tail_a),
        .peak_b           (peak_b),
        .tail_b           (tail_b),
        .hps_read         (hps_read),
        .peak_out         (peak_out),
        .tail_out         (tail_out),
        .time_out         (time_out)
    );

endmodule

// ==== test/pulse_daq_tb.sv ====
`include "pulse_daq_defines.svh"

module pulse_daq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import pulse_daq_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int PULSE_LEN    = 25;       // valid samples per pulse
    localparam int READ_LEN     = 8;        // strobe high 5, low 3
    localparam int GAP_N        = 137;      // idle cycles between the two b events
    localparam int NOISE_ROUNDS = 8;
    localparam int NOISE_LEN    = 60;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + 6 * (2 * PULSE_LEN + READ_LEN)
                                + GAP_N + NOISE_ROUNDS * (NOISE_LEN + READ_LEN);
    localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    logic       ADA_DCO;
    logic       hps_fpga_reset_n;
    sample_t    ada_d;
    sample_t    adb_d;
    logic       hps_read;
    lane_pair_t peak_out;
    lane_pair_t tail_out;
    stamp_t     time_out;

    // ====================
    // reference model state
    sample_t     win [2][`WIN_TAPS];        // index 0 is channel a
    sample_t     exp_peak [2];
    sample_t     exp_tail [2];
    int unsigned thresh [2];
    stamp_t      exp_stamp;
    stamp_t      tb_cnt;                    // dut counter value in the current cycle
    int          errors;
    lane_pair_t  want_peak;                 // values the outputs must hold
    lane_pair_t  want_tail;
    stamp_t      want_stamp;
    logic        hold_check;                // off while a read is in flight

    pulse_daq_top dut0 (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .hps_read         (hps_read),
        .peak_out         (peak_out),
        .tail_out         (tail_out),
        .time_out         (time_out)
    );

    initial
    begin
        ADA_DCO = 1'b0;
        forever #(CLK_PERIOD / 2) ADA_DCO = ~ADA_DCO;
    end

    // ====================
    // reference rules

    // counter wraps to 0 after TIME_WRAP
    function automatic stamp_t next_stamp(input stamp_t t);
        return (t == stamp_t'(`TIME_WRAP)) ? stamp_t'(0) : stamp_t'(t + 1);
    endfunction

    // local maximum above threshold, zeros when clipped
    function automatic logic expected_channel(
        input  sample_t     older,
        input  sample_t     cand,
        input  sample_t     newer,
        input  sample_t     tail_smp,
        input  int unsigned thresh_val,
        output sample_t     pk,
        output sample_t     tl
    );
        logic found;
        found = (older <= cand) && (cand >= newer) && (cand > thresh_val);
        pk = (cand >= `CLIP_LIMIT) ? sample_t'(0) : cand;
        tl = (cand >= `CLIP_LIMIT) ? sample_t'(0) : tail_smp;
        return found;
    endfunction

    function automatic lane_pair_t pack_pair(input sample_t a, input sample_t b);
        return '{pad_hi: 2'b00, lane_b: b, pad_lo: 2'b00, lane_a: a};
    endfunction

    // inverted pulse shape, baseline then rise, peak and decay
    function automatic int unsigned pulse_level(input int unsigned height, input int k);
        if (k < 3)
            return 10;
        if (k == 3 || k == 5)
            return height / 2;
        if (k == 4)
            return height;
        return height / (k - 3);                // strictly falling tail
    endfunction

    function automatic sample_t noise_code();
        logic [31:0] r;
        r = $urandom;
        if (r[31:30] == 2'b00)
            return sample_t'(r[12:0]);          // positive code, window frozen
        return sample_t'(`NEG_LIMIT + r[12:0]);
    endfunction

    // ====================
    // compare tasks

    task automatic check_pair(input string name, input lane_pair_t exp, input lane_pair_t act);
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
            $display("Done: errors found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_stamp(input string name, input stamp_t exp, input stamp_t act);
        if (act !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
            $display("Done: errors found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // outputs must match the last read at every falling edge
    always @(negedge ADA_DCO)
    begin
        if (hold_check)
        begin
            check_pair("peak_out", want_peak, peak_out);
            check_pair("tail_out", want_tail, tail_out);
            check_stamp("time_out", want_stamp, time_out);
        end
    end

    // ====================
    // stimulus

    // entered on a falling edge, returns on the next one
    task automatic drive_cycle(input sample_t code_a, input sample_t code_b);
        sample_t codes [2];
        sample_t pk;
        sample_t tl;
        ada_d    = code_a;
        adb_d    = code_b;
        codes[0] = code_a;
        codes[1] = code_b;
        for (int ch = 0; ch < 2; ch++)
        begin
            if (codes[ch] >= `NEG_LIMIT)
            begin
                if (expected_channel(win[ch][`PEAK_TAP + 1], win[ch][`PEAK_TAP],
                                     win[ch][`PEAK_TAP - 1], win[ch][`TAIL_TAP],
                                     thresh[ch], pk, tl))
                begin
                    exp_peak[ch] = pk;
                    exp_tail[ch] = tl;
                    if (ch == 1)
                    begin
                        exp_stamp = next_stamp(tb_cnt);     // latched one edge later
                    end
                end
                for (int i = `WIN_TAPS - 1; i > 0; i--)
                    win[ch][i] = win[ch][i-1];
                win[ch][0] = sample_t'(`FULL_SCALE - codes[ch]);
            end
        end
        @(negedge ADA_DCO);
        tb_cnt = next_stamp(tb_cnt);
    endtask

    task automatic send_pulse(input int ch, input int unsigned height, input bit gaps);
        sample_t code;
        for (int k = 0; k < PULSE_LEN; k++)
        begin
            if (gaps)                           // positive code before each sample
                drive_cycle(ch == 0 ? 14'd4000 : 14'd0, ch == 1 ? 14'd4000 : 14'd0);
            code = sample_t'(`FULL_SCALE - pulse_level(height, k));
            if (ch == 0)
                drive_cycle(code, 14'd0);
            else
                drive_cycle(14'd0, code);
        end
    endtask

    task automatic read_back();
        hold_check = 1'b0;
        hps_read   = 1'b1;
        repeat (5) drive_cycle('0, '0);         // sync and snapshot settle
        want_peak  = pack_pair(exp_peak[0], exp_peak[1]);
        want_tail  = pack_pair(exp_tail[0], exp_tail[1]);
        want_stamp = exp_stamp;
        hold_check = 1'b1;
        hps_read   = 1'b0;
        repeat (3) drive_cycle('0, '0);
    endtask

    // ====================
    // test sequence

    initial
    begin
        stamp_t first_stamp;
        void'($urandom(32'h5af3a4cf));
        hps_fpga_reset_n = 1'b0;
        ada_d       = '0;
        adb_d       = '0;
        hps_read    = 1'b0;
        hold_check  = 1'b0;
        errors      = 0;
        tb_cnt      = '0;
        exp_stamp   = '0;
        thresh[0]   = `PEAK_THRESH_A;
        thresh[1]   = `PEAK_THRESH_B;
        for (int ch = 0; ch < 2; ch++)
        begin
            exp_peak[ch] = '0;
            exp_tail[ch] = '0;
            for (int i = 0; i < `WIN_TAPS; i++)
                win[ch][i] = '0;
        end
        want_peak  = '0;
        want_tail  = '0;
        want_stamp = '0;
        repeat (RESET_CYCLES) @(posedge ADA_DCO);
        @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;

        hold_check = 1'b1;                      // all zero out of reset
        repeat (2) drive_cycle('0, '0);

        send_pulse(0, 5000, 1'b1);              // interleaved positive codes
        read_back();

        send_pulse(0, 8100, 1'b0);              // clipped
        read_back();
        send_pulse(0, 1000, 1'b0);              // under threshold a
        read_back();
        send_pulse(1, 1000, 1'b0);              // above threshold b
        read_back();

        // timestamp spacing between two b events
        first_stamp = time_out;
        repeat (GAP_N) drive_cycle('0, '0);
        send_pulse(1, 1000, 1'b0);
        read_back();
        // same pulse shape, both hits on the last pulse sample
        check_stamp("time_out delta", stamp_t'(READ_LEN + GAP_N + PULSE_LEN),
                    stamp_t'(time_out - first_stamp));

        for (int r = 0; r < NOISE_ROUNDS; r++)
        begin
            repeat (NOISE_LEN) drive_cycle(noise_code(), noise_code());
            read_back();
        end

        if (errors == 0)
        begin
            $display("Done: no errors");
            $finish;
        end
        else
        begin
            $display("Done: errors found");
            $fatal(1, "run ended with %0d errors", errors);
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== pulse_daq.f ====
+incdir+rtl
rtl/pulse_daq_pkg.sv
rtl/pulse_channel.sv
rtl/event_readout.sv
rtl/pulse_daq_top.sv
test/pulse_daq_tb.sv

// ==== Bender.yml ====
package:
  name: pulse_daq

export_include_dirs:
  - rtl

sources:
  - rtl/pulse_daq_pkg.sv
  - rtl/pulse_channel.sv
  - rtl/event_readout.sv
  - rtl/pulse_daq_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/pulse_daq_tb.sv
